// ==== hist_pkg.sv ====
package hist_pkg;

    localparam int num_sensors     = 4;    // sensor channels
    localparam int page_words      = 256;  // 32-bit words in one histogram page
    localparam int buf_pages       = 4;    // pages held by the buffer
    localparam int beats_per_burst = 16;   // beats in one AXI write burst
    localparam int bursts_per_page = 16;   // AXI bursts per page

    localparam logic [15:0] hist_page_base = 16'h0380; // start page table, 16 entries
    localparam logic [15:0] hist_page_mask = 16'h07f0;
    localparam logic [15:0] hist_mode_addr = 16'h0390; // mode register, exact match

    // mode word as written by command
    typedef struct packed {
        logic [23:0] unused;
        logic [3:0]  awcache;        // cache attribute for every address burst
        logic        spare;
        logic        confirm_write;  // hold each page until all responses are back
        logic        nreset;         // 0 keeps the transfer logic cleared
        logic        en;
    } mode_fields_t;

    // start page word, one per sensor and sub-channel
    typedef struct packed {
        logic [11:0] unused;
        logic [19:0] page;           // 4 KB page number in system memory
    } start_page_t;

    // one command data word, read by the address that matched
    typedef union packed {
        mode_fields_t mode;
        start_page_t  start;
    } cmd_word_u;

endpackage

// ==== hist_cmd_deser.sv ====
`timescale 1ns/1ps

module hist_cmd_deser (
    input  logic                mclk,
    input  logic                mrst,
    input  logic [7:0]          cmd_ad,   // AL, AH, D0, D1, D2, D3
    input  logic                cmd_stb,  // marks the address low byte
    output hist_pkg::cmd_word_u data,
    output logic [3:0]          page_idx, // table entry for page_we
    output logic                mode_we,
    output logic                page_we
);
    logic [2:0]  cnt;  // bytes taken, 0 when idle
    logic [47:0] sr;   // first byte ends up lowest
    logic        full; // six bytes in sr
    logic [15:0] addr;

    assign addr = sr[15:0];

    always_ff @(posedge mclk) begin
        if (mrst) begin
            cnt     <= 3'd0;
            full    <= 1'b0;
            mode_we <= 1'b0;
            page_we <= 1'b0;
        end else begin
            if (cmd_stb)            cnt <= 3'd1; // a new strobe restarts the frame
            else if (cnt == 3'd5)   cnt <= 3'd0;
            else if (cnt != 3'd0)   cnt <= cnt + 3'd1;
            full    <= (cnt == 3'd5) && !cmd_stb;
            mode_we <= full && (addr == hist_pkg::hist_mode_addr);
            page_we <= full && ((addr & hist_pkg::hist_page_mask) == hist_pkg::hist_page_base);
        end
    end

    always_ff @(posedge mclk) begin
        if (cmd_stb || cnt != 3'd0) sr <= {cmd_ad, sr[47:8]}; // shift in from the top
        if (full) begin
            data     <= sr[47:16]; // D0 is least significant
            page_idx <= addr[3:0];
        end
    end

    // mode and table ranges are disjoint
    assert property (@(posedge mclk) disable iff (mrst) !(mode_we && page_we));

endmodule

// ==== hist_cfg_regs.sv ====
`timescale 1ns/1ps

module hist_cfg_regs (
    input  logic                mclk,
    input  logic                mrst,
    input  hist_pkg::cmd_word_u data,
    input  logic [3:0]          page_idx,
    input  logic                mode_we,
    input  logic                page_we,
    input  logic [3:0]          page_sel,      // {sensor, sub-channel} from the writer
    output logic                en,
    output logic                confirm_write,
    output logic [3:0]          awcache,
    output logic [19:0]         start_page     // one cycle after page_sel
);
    hist_pkg::mode_fields_t mode;
    logic [19:0]            page_tbl [0:15];  // start page per sensor and sub-channel

    always_ff @(posedge mclk) begin
        if (mrst)         mode <= '0; // transfers off after reset
        else if (mode_we) mode <= data.mode;
    end

    always_ff @(posedge mclk) begin
        if (page_we) page_tbl[page_idx] <= data.start.page;
        start_page <= page_tbl[page_sel];
    end

    assign en            = mode.en & mode.nreset;
    assign confirm_write = mode.confirm_write;
    assign awcache       = mode.awcache;

endmodule

// ==== hist_sensor_arbiter.sv ====
`timescale 1ns/1ps

module hist_sensor_arbiter #(
    parameter int NUM_FRAME_BITS = 4
) (
    input  logic                                                mclk,
    input  logic                                                mrst,
    input  logic                                                en,
    input  logic [hist_pkg::num_sensors-1:0]                    hist_request,
    input  logic [hist_pkg::num_sensors-1:0]                    hist_dvalid,
    input  logic [hist_pkg::num_sensors-1:0][1:0]               hist_chn,
    input  logic [hist_pkg::num_sensors-1:0][NUM_FRAME_BITS-1:0] frame,
    input  logic [hist_pkg::num_sensors-1:0][31:0]              hist_data,
    output logic [hist_pkg::num_sensors-1:0]                    hist_grant,
    input  logic                                                buffer_full,
    output logic                                                wr_en,
    output logic [9:0]                                          wr_addr,   // {page, word}
    output logic [31:0]                                         wr_data,
    output logic                                                attr_we,
    output logic [3:0]                                          attr_chn,  // {sensor, sub-channel}
    output logic [NUM_FRAME_BITS-1:0]                           attr_frame,
    output logic [1:0]                                          attr_color,
    output logic                                                page_done
);
    logic [1:0]                       winner;
    logic [1:0]                       sel;     // locked sensor
    logic [hist_pkg::num_sensors-1:0] sel_hot;
    logic                             locked;  // held for a whole four-burst histogram
    logic [1:0]                       color;   // burst number within the histogram
    logic [1:0]                       page_wr; // buffer page being filled
    logic [hist_pkg::num_sensors-1:0] rq_r;
    logic                             grant_r;
    logic                             dv_mux;
    logic                             dv_r;
    logic [31:0]                      data_r;
    logic [1:0]                       chn_r;
    logic [NUM_FRAME_BITS-1:0]        frame_r;
    logic [7:0]                       word_r;

    always_comb begin
        winner = 2'd0;
        for (int i = hist_pkg::num_sensors - 1; i >= 0; i--) begin
            if (hist_request[i]) winner = 2'(i); // lowest number wins
        end
    end

    assign sel_hot = (hist_pkg::num_sensors)'(1) << sel;
    assign dv_mux  = hist_dvalid[sel];

    always_ff @(posedge mclk) begin
        if (mrst || !en) begin
            locked    <= 1'b0;
            sel       <= 2'd0;
            color     <= 2'd0;
            page_wr   <= 2'd0;
            rq_r      <= '0;
            grant_r   <= 1'b0;
            dv_r      <= 1'b0;
            attr_we   <= 1'b0;
            page_done <= 1'b0;
        end else begin
            rq_r      <= hist_request;
            dv_r      <= dv_mux;
            attr_we   <= dv_mux && !dv_r; // first beat of a burst
            page_done <= dv_r && !dv_mux; // dvalid fell
            // buffer_full lags page_done by a cycle
            grant_r   <= locked && rq_r[sel] && !buffer_full && !page_done;
            if (!locked && |hist_request) begin
                locked <= 1'b1;
                sel    <= winner;
            end else if (page_done) begin
                color   <= color + 2'd1;
                page_wr <= page_wr + 2'd1;
                if (color == 2'd3) locked <= 1'b0; // fourth color done
            end
        end
    end

    always_ff @(posedge mclk) begin
        data_r  <= hist_data[sel];
        chn_r   <= hist_chn[sel];
        frame_r <= frame[sel];
        word_r  <= dv_r ? word_r + 8'd1 : 8'd0;
    end

    assign hist_grant = grant_r ? sel_hot : '0;
    assign wr_en      = dv_r;
    assign wr_addr    = {page_wr, word_r};
    assign wr_data    = data_r;
    assign attr_chn   = {sel, chn_r};
    assign attr_frame = frame_r;
    assign attr_color = color;

    // sensors stream only while they hold the lock
    assert property (@(posedge mclk) disable iff (mrst)
        (hist_dvalid & ~({hist_pkg::num_sensors{locked}} & sel_hot)) == '0);

endmodule

// ==== hist_page_buffer.sv ====
`timescale 1ns/1ps

module hist_page_buffer #(
    parameter int NUM_FRAME_BITS = 4
) (
    input  logic                      mclk,
    input  logic                      mrst,
    input  logic                      en,
    input  logic                      wr_en,
    input  logic [9:0]                wr_addr,
    input  logic [31:0]               wr_data,
    input  logic                      attr_we,
    input  logic [3:0]                attr_chn,
    input  logic [NUM_FRAME_BITS-1:0] attr_frame,
    input  logic [1:0]                attr_color,
    input  logic                      page_done,
    output logic                      buffer_full,
    output logic                      pages_avail,
    input  logic                      rd_en,
    input  logic [7:0]                rd_addr,
    output logic [31:0]               rd_data,     // one cycle after rd_en
    output logic [3:0]                head_chn,
    output logic [NUM_FRAME_BITS-1:0] head_frame,
    output logic [1:0]                head_color,
    input  logic                      page_sent    // frees the oldest page
);
    localparam int ATTR_W = NUM_FRAME_BITS + 6; // chn, frame, color

    logic [31:0]       ram      [0:hist_pkg::buf_pages*hist_pkg::page_words-1];
    logic [ATTR_W-1:0] attr_mem [0:hist_pkg::buf_pages-1];
    logic [1:0]        wr_page;  // page the arbiter fills
    logic [1:0]        rd_page;  // oldest page held
    logic [2:0]        count;    // pages held, 0..4

    assign wr_page = wr_addr[9:8];

    always_ff @(posedge mclk) begin
        if (wr_en)   ram[wr_addr] <= wr_data;
        if (rd_en)   rd_data <= ram[{rd_page, rd_addr}];
        if (attr_we) attr_mem[wr_page] <= {attr_chn, attr_frame, attr_color}; // with first word
    end

    always_ff @(posedge mclk) begin
        if (mrst || !en) begin
            rd_page <= 2'd0;
            count   <= 3'd0;
        end else begin
            if (page_sent) rd_page <= rd_page + 2'd1;
            case ({page_done, page_sent})
                2'b10:   count <= count + 3'd1;
                2'b01:   count <= count - 3'd1;
                default: count <= count;      // both or neither
            endcase
        end
    end

    assign buffer_full = (count == 3'(hist_pkg::buf_pages));
    assign pages_avail = (count != 3'd0);
    assign {head_chn, head_frame, head_color} = attr_mem[rd_page];

    // a 3-bit count wraps to 7 when a page is freed twice
    assert property (@(posedge mclk) disable iff (mrst) count <= 3'(hist_pkg::buf_pages));

endmodule

// ==== hist_axi_writer.sv ====
`timescale 1ns/1ps

module hist_axi_writer #(
    parameter int NUM_FRAME_BITS = 4
) (
    input  logic                      mclk,
    input  logic                      mrst,
    input  logic                      en,
    input  logic                      confirm_write,
    input  logic [3:0]                cfg_awcache,
    output logic [3:0]                page_sel,
    input  logic [19:0]               start_page,
    input  logic                      pages_avail,
    output logic                      rd_en,
    output logic [7:0]                rd_addr,
    input  logic [31:0]               rd_data,
    input  logic [3:0]                head_chn,
    input  logic [NUM_FRAME_BITS-1:0] head_frame,
    input  logic [1:0]                head_color,
    output logic                      page_sent,
    output logic                      awvalid,
    input  logic                      awready,
    output logic [31:0]               awaddr,
    output logic [5:0]                awid,
    output logic [3:0]                awcache,
    output logic                      wvalid,
    input  logic                      wready,
    output logic [31:0]               wdata,
    output logic                      wlast,
    input  logic                      bvalid       // bready is always high
);
    logic                      busy;      // one page in progress
    logic                      start_w;
    logic [2:0]                stg;       // head latched, start page read, base formed
    logic [3:0]                chn_r;
    logic [NUM_FRAME_BITS-1:0] frame_r;
    logic [1:0]                color_r;
    logic                      confirm_r;
    logic [19:0]               base_r;
    logic [4:0]                aw_left;   // address bursts still to issue
    logic [4:0]                w_left;    // data bursts still to send
    logic [7:0]                b_out;     // bursts sent without response
    logic [3:0]                beat;
    logic                      rd_run;
    logic                      rd_v;      // rd_data valid this cycle
    logic [31:0]               fifo [0:3];
    logic [1:0]                wp;
    logic [1:0]                rp;
    logic [2:0]                fcnt;
    logic                      aw_hs;
    logic                      w_hs;
    logic                      done_w;

    // the buffer count is stale in the page_sent cycle
    assign start_w = en && !busy && pages_avail && !page_sent;
    assign aw_hs   = awvalid && awready;
    assign w_hs    = wvalid && wready;
    assign awvalid = (aw_left != 5'd0);
    assign wvalid  = (fcnt != 3'd0) && (aw_left < w_left); // data only behind its address
    assign wlast   = &beat;
    assign wdata   = fifo[rp];
    assign rd_en   = rd_run && (fcnt + 3'(rd_v) < 3'd4);   // room for reads in flight
    assign done_w  = busy && (stg == 3'd0) && (w_left == 5'd0) && (!confirm_r || b_out == 8'd0);
    assign page_sel = chn_r;
    assign awid     = {chn_r, color_r};

    always_ff @(posedge mclk) begin
        if (mrst || !en) begin
            busy      <= 1'b0;
            stg       <= 3'd0;
            page_sent <= 1'b0;
            aw_left   <= 5'd0;
            w_left    <= 5'd0;
            b_out     <= 8'd0;
            beat      <= 4'd0;
            rd_run    <= 1'b0;
            rd_v      <= 1'b0;
            wp        <= 2'd0;
            rp        <= 2'd0;
            fcnt      <= 3'd0;
        end else begin
            stg       <= {stg[1:0], start_w};
            page_sent <= done_w;
            rd_v      <= rd_en;
            if (start_w)     busy <= 1'b1;
            else if (done_w) busy <= 1'b0;
            if (stg[2])     aw_left <= 5'(hist_pkg::bursts_per_page);
            else if (aw_hs) aw_left <= aw_left - 5'd1;
            if (stg[2])              w_left <= 5'(hist_pkg::bursts_per_page);
            else if (w_hs && wlast)  w_left <= w_left - 5'd1;
            b_out <= b_out + 8'(w_hs && wlast) - 8'(bvalid);
            if (w_hs) beat <= beat + 4'd1; // wraps every burst
            if (stg[2])                    rd_run <= 1'b1;
            else if (rd_en && &rd_addr)    rd_run <= 1'b0; // last word of the page
            if (rd_v) wp <= wp + 2'd1;
            if (w_hs) rp <= rp + 2'd1;
            fcnt <= fcnt + 3'(rd_v) - 3'(w_hs);
        end
    end

    always_ff @(posedge mclk) begin
        if (start_w) begin
            chn_r     <= head_chn;
            frame_r   <= head_frame;
            color_r   <= head_color;
            confirm_r <= confirm_write; // mode is fixed for the whole page
            awcache   <= cfg_awcache;
        end
        if (stg[1]) base_r <= start_page + 20'(frame_r);
        if (stg[2])     awaddr <= {base_r, color_r, 10'd0}; // 1 KB per color
        else if (aw_hs) awaddr <= awaddr + 32'(hist_pkg::beats_per_burst * 4);
        if (stg[2])     rd_addr <= 8'd0;
        else if (rd_en) rd_addr <= rd_addr + 8'd1;
        if (rd_v) fifo[wp] <= rd_data;
    end

    // address and valid hold under awready back-pressure
    assert property (@(posedge mclk) disable iff (mrst || !en)
        awvalid && !awready |=> awvalid && $stable(awaddr));

endmodule

// ==== hist_saxi_top.sv ====
`timescale 1ns/1ps

module hist_saxi_top #(
    parameter int NUM_FRAME_BITS = 4
) (
    input  logic                      mclk,
    input  logic                      mrst,
    input  logic [NUM_FRAME_BITS-1:0] frame0,
    input  logic                      hist_request0,
    output logic                      hist_grant0,
    input  logic [1:0]                hist_chn0,
    input  logic                      hist_dvalid0,
    input  logic [31:0]               hist_data0,
    input  logic [NUM_FRAME_BITS-1:0] frame1,
    input  logic                      hist_request1,
    output logic                      hist_grant1,
    input  logic [1:0]                hist_chn1,
    input  logic                      hist_dvalid1,
    input  logic [31:0]               hist_data1,
    input  logic [NUM_FRAME_BITS-1:0] frame2,
    input  logic                      hist_request2,
    output logic                      hist_grant2,
    input  logic [1:0]                hist_chn2,
    input  logic                      hist_dvalid2,
    input  logic [31:0]               hist_data2,
    input  logic [NUM_FRAME_BITS-1:0] frame3,
    input  logic                      hist_request3,
    output logic                      hist_grant3,
    input  logic [1:0]                hist_chn3,
    input  logic                      hist_dvalid3,
    input  logic [31:0]               hist_data3,
    input  logic [7:0]                cmd_ad,
    input  logic                      cmd_stb,
    output logic                      awvalid,
    input  logic                      awready,
    output logic [31:0]               awaddr,
    output logic [5:0]                awid,
    output logic [3:0]                awcache,
    output logic                      wvalid,
    input  logic                      wready,
    output logic [31:0]               wdata,
    output logic                      wlast,
    input  logic                      bvalid
);
    hist_pkg::cmd_word_u       cmd_data;
    logic [3:0]                page_idx;
    logic                      mode_we;
    logic                      page_we;
    logic                      en;
    logic                      confirm_write;
    logic [3:0]                cfg_awcache;
    logic [3:0]                page_sel;
    logic [19:0]               start_page;
    logic                      wr_en;
    logic [9:0]                wr_addr;
    logic [31:0]               wr_data;
    logic                      attr_we;
    logic [3:0]                attr_chn;
    logic [NUM_FRAME_BITS-1:0] attr_frame;
    logic [1:0]                attr_color;
    logic                      page_done;
    logic                      buffer_full;
    logic                      pages_avail;
    logic                      rd_en;
    logic [7:0]                rd_addr;
    logic [31:0]               rd_data;
    logic [3:0]                head_chn;
    logic [NUM_FRAME_BITS-1:0] head_frame;
    logic [1:0]                head_color;
    logic                      page_sent;

    hist_cmd_deser cmd_deser_i (
        .mclk(mclk), .mrst(mrst), .cmd_ad(cmd_ad), .cmd_stb(cmd_stb),
        .data(cmd_data), .page_idx(page_idx), .mode_we(mode_we), .page_we(page_we)
    );

    hist_cfg_regs cfg_regs_i (
        .mclk(mclk), .mrst(mrst), .data(cmd_data), .page_idx(page_idx),
        .mode_we(mode_we), .page_we(page_we), .page_sel(page_sel), .en(en),
        .confirm_write(confirm_write), .awcache(cfg_awcache), .start_page(start_page)
    );

    hist_sensor_arbiter #(.NUM_FRAME_BITS(NUM_FRAME_BITS)) sensor_arbiter_i (
        .mclk(mclk), .mrst(mrst), .en(en),
        .hist_request({hist_request3, hist_request2, hist_request1, hist_request0}),
        .hist_dvalid({hist_dvalid3, hist_dvalid2, hist_dvalid1, hist_dvalid0}),
        .hist_chn({hist_chn3, hist_chn2, hist_chn1, hist_chn0}),
        .frame({frame3, frame2, frame1, frame0}),
        .hist_data({hist_data3, hist_data2, hist_data1, hist_data0}),
        .hist_grant({hist_grant3, hist_grant2, hist_grant1, hist_grant0}),
        .buffer_full(buffer_full), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .attr_we(attr_we), .attr_chn(attr_chn), .attr_frame(attr_frame),
        .attr_color(attr_color), .page_done(page_done)
    );

    hist_page_buffer #(.NUM_FRAME_BITS(NUM_FRAME_BITS)) page_buffer_i (
        .mclk(mclk), .mrst(mrst), .en(en), .wr_en(wr_en), .wr_addr(wr_addr),
        .wr_data(wr_data), .attr_we(attr_we), .attr_chn(attr_chn),
        .attr_frame(attr_frame), .attr_color(attr_color), .page_done(page_done),
        .buffer_full(buffer_full), .pages_avail(pages_avail), .rd_en(rd_en),
        .rd_addr(rd_addr), .rd_data(rd_data), .head_chn(head_chn),
        .head_frame(head_frame), .head_color(head_color), .page_sent(page_sent)
    );

    hist_axi_writer #(.NUM_FRAME_BITS(NUM_FRAME_BITS)) axi_writer_i (
        .mclk(mclk), .mrst(mrst), .en(en), .confirm_write(confirm_write),
        .cfg_awcache(cfg_awcache), .page_sel(page_sel), .start_page(start_page),
        .pages_avail(pages_avail), .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
        .head_chn(head_chn), .head_frame(head_frame), .head_color(head_color),
        .page_sent(page_sent), .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .awid(awid), .awcache(awcache), .wvalid(wvalid), .wready(wready),
        .wdata(wdata), .wlast(wlast), .bvalid(bvalid)
    );

endmodule

// ==== tb_hist_saxi.sv ====
`timescale 1ns/1ps

module tb_hist_saxi;
    localparam int FRAME_BITS  = 4;
    localparam int TOTAL_WORDS = 10 * 1024;                // tests 2 to 5 with four pages per sensor
    localparam int WATCH_CYC   = 4 * TOTAL_WORDS * 8 + 10000;

    logic                       mclk = 1'b0;
    logic                       mrst;
    logic [3:0]                 req;
    logic [3:0]                 dv;
    logic [3:0]                 grant;
    logic [3:0][1:0]            chn;
    logic [3:0][FRAME_BITS-1:0] frm;
    logic [3:0][31:0]           dat;
    logic [7:0]                 cmd_ad;
    logic                       cmd_stb;
    logic                       awvalid, awready, wvalid, wready, wlast, bvalid;
    logic [31:0]                awaddr, wdata;
    logic [5:0]                 awid;
    logic [3:0]                 awcache;

    logic [31:0] mem_exp   [logic [31:0]]; // expected word per byte address
    logic [5:0]  burst_exp [logic [31:0]]; // expected awid per burst address
    logic [31:0] aw_q [$];                 // accepted addresses awaiting data
    int          b_due [$];                // cycle for each pending response
    logic [19:0] sp [0:15];                // programmed start pages
    logic [3:0]  grant_prev;
    logic [3:0]  dv_prev;                  // sensor dvalid seen on the last falling edge
    logic [3:0]  cur_cache;
    bit          cur_confirm;
    int          aw_cnt [0:3];
    int          cyc, last_due, beat, aw_total;
    int          pages_held;               // pages filled and not yet fully written out
    int          sent_cnt;                 // bursts of the oldest page already finished
    int          errors, checks, tests;
    bit          bp_on, saw_full;

    always #2 mclk = ~mclk; // 4 ns period

    hist_saxi_top #(.NUM_FRAME_BITS(FRAME_BITS)) dut_i (
        .mclk(mclk), .mrst(mrst),
        .frame0(frm[0]), .hist_request0(req[0]), .hist_grant0(grant[0]),
        .hist_chn0(chn[0]), .hist_dvalid0(dv[0]), .hist_data0(dat[0]),
        .frame1(frm[1]), .hist_request1(req[1]), .hist_grant1(grant[1]),
        .hist_chn1(chn[1]), .hist_dvalid1(dv[1]), .hist_data1(dat[1]),
        .frame2(frm[2]), .hist_request2(req[2]), .hist_grant2(grant[2]),
        .hist_chn2(chn[2]), .hist_dvalid2(dv[2]), .hist_data2(dat[2]),
        .frame3(frm[3]), .hist_request3(req[3]), .hist_grant3(grant[3]),
        .hist_chn3(chn[3]), .hist_dvalid3(dv[3]), .hist_data3(dat[3]),
        .cmd_ad(cmd_ad), .cmd_stb(cmd_stb),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr), .awid(awid),
        .awcache(awcache), .wvalid(wvalid), .wready(wready), .wdata(wdata),
        .wlast(wlast), .bvalid(bvalid)
    );

    task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        assert (exp == act) else begin
            $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(bit cond, string what);
        checks++;
        assert (cond) else begin
            $display("ERROR at %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic write_cmd(logic [15:0] addr, logic [31:0] value);
        logic [47:0] bytes;
        bytes = {value, addr};                       // AL goes out first
        for (int i = 0; i < 6; i++) begin
            @(posedge mclk);
            cmd_stb <= (i == 0);
            cmd_ad  <= bytes[i*8 +: 8];
        end
        @(posedge mclk);
        cmd_stb <= 1'b0;
        repeat (4) @(posedge mclk);                  // lands two cycles after the last byte
    endtask

    task automatic set_mode(bit confirm, logic [3:0] cache);
        write_cmd(hist_pkg::hist_mode_addr, {24'd0, cache, 1'b0, confirm, 1'b1, 1'b1});
        cur_cache   = cache;
        cur_confirm = confirm;
    endtask

    task automatic program_pages();
        logic [19:0] base;
        base = 20'($urandom) & 20'hff000;
        for (int i = 0; i < 16; i++) begin
            sp[i] = base + 20'(i * 32);              // frames never reach the next entry
            write_cmd(hist_pkg::hist_page_base + 16'(i), {12'd0, sp[i]});
        end
    endtask

    // one four-color histogram from sensor s
    task automatic run_histogram(int s);
        logic [1:0]            c;
        logic [FRAME_BITS-1:0] f;
        logic [19:0]           pg;
        logic [31:0]           a;
        logic [31:0]           d;
        c  = 2'($urandom);
        f  = FRAME_BITS'($urandom);
        pg = sp[s * 4 + int'(c)] + 20'(f);
        for (int color = 0; color < 4; color++) begin
            @(posedge mclk);
            req[s] <= 1'b1;
            chn[s] <= c;
            frm[s] <= f;
            do @(posedge mclk); while (!grant[s]);
            req[s] <= 1'b0;
            for (int w = 0; w < hist_pkg::page_words; w++) begin
                d = $urandom;
                a = 32'(pg) * 32'd4096 + 32'(color) * 32'd1024 + 32'(w) * 32'd4;
                mem_exp[a] = d;
                if (w % hist_pkg::beats_per_burst == 0)
                    burst_exp[a] = {2'(s), c, 2'(color)};
                @(posedge mclk);
                dv[s]  <= 1'b1;
                dat[s] <= d;
            end
            @(posedge mclk);
            dv[s] <= 1'b0;
        end
    endtask

    task automatic drain();
        while (mem_exp.num() != 0 || burst_exp.num() != 0 || b_due.size() != 0)
            @(posedge mclk);
        repeat (20) @(posedge mclk);
    endtask

    task automatic end_test(string name, int err0);
        tests++;
        $display("test %0d %s: %s, %0d errors", tests, name,
                 (errors == err0) ? "ok" : "failed", errors - err0);
    endtask

    // AXI slave handshake drive and delayed responses
    always @(posedge mclk) begin
        cyc     <= cyc + 1;
        awready <= bp_on ? ($urandom % 3 != 0) : 1'b1;
        wready  <= bp_on ? ($urandom % 3 != 0) : 1'b1;
        bvalid  <= 1'b0;
        if (b_due.size() != 0 && b_due[0] <= cyc) begin
            bvalid <= 1'b1;
            void'(b_due.pop_front());
        end
    end

    // monitor at the falling edge where every DUT output is settled
    always @(negedge mclk) begin : monitor
        logic [31:0] a;
        int          s;
        int          due;
        if (!mrst) begin
            if (awvalid && awready) begin
                if (burst_exp.exists(awaddr)) begin
                    s = int'(awid[5:4]);
                    check_val("awid", 32'(burst_exp[awaddr]), 32'(awid));
                    check_val("awcache", 32'(cur_cache), 32'(awcache));
                    check_val("awid color", 32'((aw_cnt[s] / 16) % 4), 32'(awid[1:0]));
                    aw_cnt[s]++;
                    burst_exp.delete(awaddr);
                end else begin
                    check_true(1'b0, "address burst at an unexpected or repeated awaddr");
                end
                aw_q.push_back(awaddr);
                aw_total++;
            end
            if (wvalid && wready) begin
                if (aw_q.size() == 0) begin
                    check_true(1'b0, "write data arrived ahead of its address");
                end else begin
                    a = aw_q[0] + 32'(beat * 4);
                    if (mem_exp.exists(a)) begin
                        check_val("wdata", mem_exp[a], wdata);
                        mem_exp.delete(a);
                    end else begin
                        check_true(1'b0, "data beat for an unexpected or repeated address");
                    end
                    check_val("wlast", 32'(beat == 15), 32'(wlast));
                    beat = (beat + 1) % 16;
                    if (beat == 0) begin
                        void'(aw_q.pop_front());
                        due = cyc + 1 + (bp_on ? int'($urandom % 20) : 0);
                        if (b_due.size() != 0 && due <= last_due) due = last_due + 1;
                        last_due = due;
                        b_due.push_back(due);
                        if (!cur_confirm) sent_cnt++;   // page freed by its last data
                    end
                end
            end
            if (bvalid && cur_confirm) sent_cnt++;  // page freed by its last response
            if (sent_cnt == hist_pkg::bursts_per_page) begin
                sent_cnt = 0;
                pages_held--;
            end
            pages_held += $countones(dv_prev & ~dv); // a sensor burst ended
            if (pages_held >= hist_pkg::buf_pages) saw_full = 1'b1;
            if ((grant & ~grant_prev) != 4'd0)
                check_true(pages_held < hist_pkg::buf_pages,
                           "grant issued while four pages were waiting to be sent");
            grant_prev = grant;
            dv_prev    = dv;
        end
    end

    initial begin
        repeat (WATCH_CYC) @(posedge mclk);
        $display("watchdog expired before the tests completed");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int err0;
        int aw0;
        void'($urandom(32'h419a_cca5));
        mrst        = 1'b1;
        req         = '0;
        dv          = '0;
        chn         = '0;
        frm         = '0;
        dat         = '0;
        cmd_ad      = 8'd0;
        cmd_stb     = 1'b0;
        awready     = 1'b0;
        wready      = 1'b0;
        bvalid      = 1'b0;
        grant_prev  = '0;
        dv_prev     = '0;
        cur_cache   = '0;
        cur_confirm = 1'b0;
        cyc         = 0;
        last_due    = 0;
        beat        = 0;
        aw_total    = 0;
        pages_held  = 0;
        sent_cnt    = 0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        bp_on       = 1'b0;
        saw_full    = 1'b0;
        for (int i = 0; i < 4; i++) aw_cnt[i] = 0;
        repeat (10) @(posedge mclk);
        mrst <= 1'b0;
        repeat (5) @(posedge mclk);

        err0 = errors;                               // transfers off after reset
        req[0] <= 1'b1;
        repeat (200) begin
            @(negedge mclk);
            check_true(grant == 4'd0 && !awvalid && !wvalid, "activity while disabled");
        end
        @(posedge mclk);
        req[0] <= 1'b0;
        end_test("disabled after reset", err0);

        err0 = errors;
        program_pages();
        set_mode(1'b0, 4'h3);
        aw0 = aw_total;
        run_histogram(2);
        drain();
        check_val("address bursts", 32'd64, 32'(aw_total - aw0));
        end_test("single histogram sensor 2", err0);

        err0 = errors;
        set_mode(1'b0, 4'ha);
        run_histogram(1);
        drain();
        end_test("awid and awcache", err0);

        err0 = errors;
        fork
            run_histogram(0);
            run_histogram(1);
            run_histogram(2);
            run_histogram(3);
        join
        drain();
        end_test("four sensors at once", err0);

        err0 = errors;
        program_pages();
        set_mode(1'b1, 4'h6);
        bp_on    = 1'b1;
        saw_full = 1'b0;
        fork
            run_histogram(3);
            run_histogram(2);
            run_histogram(1);
            run_histogram(0);
        join
        drain();
        check_true(saw_full, "page buffer never filled under back-pressure");
        end_test("back-pressure with confirm_write", err0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== src.f ====
hist_pkg.sv
hist_cmd_deser.sv
hist_cfg_regs.sv
hist_sensor_arbiter.sv
hist_page_buffer.sv
hist_axi_writer.sv
hist_saxi_top.sv
tb_hist_saxi.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_hist_saxi
FILELIST  = src.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF "** PASS **"

clean:
	rm -rf obj_dir
